// File: src/qla_consts.svh
// QLA register core constants
`ifndef QLA_CONSTS_SVH
`define QLA_CONSTS_SVH

// ---------------------------------------------------------------------------
// bus widths
// ---------------------------------------------------------------------------
`define QLA_ADDR_W        16      // register address
`define QLA_DATA_W        32      // register data word
`define QLA_NUM_AXES      4       // axes on one board
`define QLA_ENC_W         24      // quadrature count
`define QLA_CMD_W         16      // commanded current

// ---------------------------------------------------------------------------
// address map: space [15:12], rsvd [11:8], channel [7:4], offset [3:0]
// ---------------------------------------------------------------------------
`define QLA_ADDR_MAIN     4'h0    // main register space

// channel 0 is the board itself
`define QLA_OFF_STATUS    4'h0    // board status / amp enable

// channels 1..4 are the axes
`define QLA_OFF_DAC_CTRL  4'h0    // current command
`define QLA_OFF_ENC_LOAD  4'h4    // encoder preload
`define QLA_OFF_ENC_DATA  4'h5    // encoder count

// ---------------------------------------------------------------------------
// depths and filters
// ---------------------------------------------------------------------------
`define QLA_RSP_DEPTH     4       // response slots, also host credits at reset
`define QLA_FAULT_FILTER  8       // consecutive low samples before trip

`endif

// File: src/qla_pkg.sv
// QLA register word types
`include "qla_consts.svh"

package qla_pkg;

    // amplifier enable command, written to channel 0 status
    typedef struct packed {
        logic [15-`QLA_NUM_AXES:0]  rsvd_hi;  // bits 31..20
        logic [`QLA_NUM_AXES-1:0]   mask;     // bits 19..16, per-axis write mask
        logic [15-`QLA_NUM_AXES:0]  rsvd_lo;  // bits 15..4
        logic [`QLA_NUM_AXES-1:0]   en;       // bits 3..0, enable request
    } amp_cmd_t;

    // current command word for the DAC
    typedef struct packed {
        logic [`QLA_DATA_W-`QLA_CMD_W-1:0] rsvd;
        logic [`QLA_CMD_W-1:0]             cmd;   // signed offset binary
    } dac_t;

    // encoder preload, also used for the count read word
    typedef struct packed {
        logic [`QLA_DATA_W-`QLA_ENC_W-1:0] rsvd;
        logic [`QLA_ENC_W-1:0]             value;
    } preload_t;

    // one register word, decoded by whichever block owns the address
    typedef union packed {
        amp_cmd_t amp_cmd;
        dac_t     dac;
        preload_t preload;
    } reg_word_u;

endpackage

// File: src/qla_reg_bus_if.sv
// QLA internal register bus
`include "qla_consts.svh"

interface qla_reg_bus_if
    import qla_pkg::*;
();

    // ---------------------------------------------------------------------
    // write side, driven by the top from the host port
    // ---------------------------------------------------------------------
    logic                   wen;     // one-cycle write strobe
    logic [`QLA_ADDR_W-1:0] waddr;
    reg_word_u              wdata;

    // read address, driven by the read path from the request
    logic [`QLA_ADDR_W-1:0] raddr;

    // register blocks only listen
    modport blk (input wen, input waddr, input wdata, input raddr);

    // read path owns the read address
    modport rd (output raddr);

endinterface

// File: src/qla_enc_ctrl.sv
// QLA quadrature encoder controller
`include "qla_consts.svh"

module qla_enc_ctrl
    import qla_pkg::*;
(
    input  logic                     sysclk,
    input  logic                     rst,
    qla_reg_bus_if.blk               bus,
    input  logic [`QLA_NUM_AXES-1:0] enc_a,
    input  logic [`QLA_NUM_AXES-1:0] enc_b,
    output logic [`QLA_DATA_W-1:0]   enc_rdata
);

    localparam int AX_W = $clog2(`QLA_NUM_AXES);

    // pin synchronizers plus one history stage
    logic [`QLA_NUM_AXES-1:0] a_s1, a_s2, a_d;
    logic [`QLA_NUM_AXES-1:0] b_s1, b_s2, b_d;
    logic [`QLA_NUM_AXES-1:0] step;   // exactly one of a/b moved
    logic [`QLA_NUM_AXES-1:0] up;     // direction of that step

    logic [`QLA_ENC_W-1:0] preload [`QLA_NUM_AXES];
    logic [`QLA_ENC_W-1:0] count   [`QLA_NUM_AXES];

    // write decode
    logic [3:0]      w_chan;
    logic            w_axis_ok;
    logic [AX_W-1:0] w_ax;
    logic            ld_hit;

    // read decode
    logic [3:0]      r_chan;
    logic            r_axis_ok;
    logic [AX_W-1:0] r_ax;
    reg_word_u       rd_word;

    // -----------------------------------------------------------------------
    // pin sampling and 4x decode
    // -----------------------------------------------------------------------

    // no reset here, the flops settle while rst holds the counters
    always_ff @(posedge sysclk) begin
        a_s1 <= enc_a;
        b_s1 <= enc_b;
        a_s2 <= a_s1;
        b_s2 <= b_s1;
        a_d  <= a_s2;   // previous state
        b_d  <= b_s2;
    end

    // both bits changing is an illegal double step, dropped
    assign step = (a_s2 ^ a_d) ^ (b_s2 ^ b_d);
    assign up   = a_s2 ^ b_d;    // a leading b counts up

    // -----------------------------------------------------------------------
    // preload and counters
    // -----------------------------------------------------------------------
    assign w_chan    = bus.waddr[7:4];
    assign w_axis_ok = (w_chan >= 4'd1) && (w_chan <= 4'(`QLA_NUM_AXES));
    assign w_ax      = AX_W'(w_chan - 4'd1);
    assign ld_hit    = bus.wen && w_axis_ok
                    && (bus.waddr[15:12] == `QLA_ADDR_MAIN)
                    && (bus.waddr[3:0] == `QLA_OFF_ENC_LOAD);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                preload[i] <= '0;
                count[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (ld_hit && (w_ax == AX_W'(i))) begin
                    // host load wins over a step in the same cycle
                    preload[i] <= bus.wdata.preload.value;
                    count[i]   <= bus.wdata.preload.value;
                end else if (step[i]) begin
                    count[i] <= up[i] ? count[i] + 1'b1 : count[i] - 1'b1;   // wraps mod 2^24
                end
            end
        end
    end

    // -----------------------------------------------------------------------
    // read select
    // -----------------------------------------------------------------------
    assign r_chan    = bus.raddr[7:4];
    assign r_axis_ok = (r_chan >= 4'd1) && (r_chan <= 4'(`QLA_NUM_AXES));
    assign r_ax      = AX_W'(r_chan - 4'd1);

    always_comb begin
        rd_word = '0;   // zero-extended, unmapped reads give zero
        if (r_axis_ok) begin
            if (bus.raddr[3:0] == `QLA_OFF_ENC_LOAD) begin
                rd_word.preload.value = preload[r_ax];
            end else if (bus.raddr[3:0] == `QLA_OFF_ENC_DATA) begin
                rd_word.preload.value = count[r_ax];
            end
        end
    end

    assign enc_rdata = rd_word;

endmodule

// File: src/qla_motor_chan.sv
// QLA motor channel registers
`include "qla_consts.svh"

module qla_motor_chan
    import qla_pkg::*;
(
    input  logic                     sysclk,
    input  logic                     rst,
    qla_reg_bus_if.blk               bus,
    input  logic [3:0]               board_id,      // rotary switch
    input  logic [`QLA_NUM_AXES-1:0] amp_fault_n,   // low = amp fault
    output logic [`QLA_NUM_AXES-1:0] amp_en,
    output logic [`QLA_DATA_W-1:0]   mot_rdata
);

    localparam int AX_W  = $clog2(`QLA_NUM_AXES);
    localparam int FLT_W = $clog2(`QLA_FAULT_FILTER);
    localparam logic [FLT_W-1:0] FLT_LAST = FLT_W'(`QLA_FAULT_FILTER - 1);

    logic [`QLA_CMD_W-1:0]    cur_cmd [`QLA_NUM_AXES];   // register only, no DAC here
    logic [`QLA_NUM_AXES-1:0] en_reg;      // host enable request
    logic [`QLA_NUM_AXES-1:0] safety;      // latched safety disable
    logic [`QLA_NUM_AXES-1:0] flt_s1, flt_s2;
    logic [FLT_W-1:0]         flt_cnt [`QLA_NUM_AXES];

    logic                     w_main;
    logic [3:0]               w_chan;
    logic                     hit_status;
    logic                     hit_dac;
    logic [AX_W-1:0]          w_ax;
    logic [`QLA_NUM_AXES-1:0] clr_safety;

    logic [3:0]               r_chan;
    reg_word_u                rd_word;

    // -----------------------------------------------------------------------
    // write decode
    // -----------------------------------------------------------------------
    assign w_main     = (bus.waddr[15:12] == `QLA_ADDR_MAIN);
    assign w_chan     = bus.waddr[7:4];
    assign w_ax       = AX_W'(w_chan - 4'd1);
    assign hit_status = bus.wen && w_main && (w_chan == 4'd0)
                     && (bus.waddr[3:0] == `QLA_OFF_STATUS);
    assign hit_dac    = bus.wen && w_main && (w_chan >= 4'd1)
                     && (w_chan <= 4'(`QLA_NUM_AXES))
                     && (bus.waddr[3:0] == `QLA_OFF_DAC_CTRL);

    // re-enabling an axis clears its trip
    assign clr_safety = hit_status ? (bus.wdata.amp_cmd.en & bus.wdata.amp_cmd.mask) : '0;

    // fault pins, settle during reset
    always_ff @(posedge sysclk) begin
        flt_s1 <= amp_fault_n;
        flt_s2 <= flt_s1;
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            en_reg <= '0;
            safety <= '0;
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                cur_cmd[i] <= '0;
                flt_cnt[i] <= '0;
            end
        end else begin
            if (hit_status)   // only masked bits move
                en_reg <= (en_reg & ~bus.wdata.amp_cmd.mask)
                        | (bus.wdata.amp_cmd.en & bus.wdata.amp_cmd.mask);
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (hit_dac && (w_ax == AX_W'(i)))
                    cur_cmd[i] <= bus.wdata.dac.cmd;
                // consecutive low samples while the amp is driven
                if (!amp_en[i] || flt_s2[i])
                    flt_cnt[i] <= '0;
                else if (flt_cnt[i] != FLT_LAST)
                    flt_cnt[i] <= flt_cnt[i] + 1'b1;
                if (clr_safety[i])
                    safety[i] <= 1'b0;   // clear beats a new trip
                else if (amp_en[i] && !flt_s2[i] && (flt_cnt[i] == FLT_LAST))
                    safety[i] <= 1'b1;   // 8th low sample
            end
        end
    end

    assign amp_en = en_reg & ~safety;

    // -----------------------------------------------------------------------
    // read select
    // -----------------------------------------------------------------------
    assign r_chan = bus.raddr[7:4];

    always_comb begin
        rd_word = '0;
        if (bus.raddr[3:0] == `QLA_OFF_STATUS && r_chan == 4'd0) begin
            rd_word = {4'd0, board_id, 4'd0, flt_s2, 8'd0, safety, en_reg};
        end else if (bus.raddr[3:0] == `QLA_OFF_DAC_CTRL
                     && r_chan >= 4'd1 && r_chan <= 4'(`QLA_NUM_AXES)) begin
            rd_word.dac.cmd = cur_cmd[AX_W'(r_chan - 4'd1)];
        end
    end

    assign mot_rdata = rd_word;

endmodule

// File: src/qla_read_path.sv
// QLA read path and response queue
`include "qla_consts.svh"

module qla_read_path
    import qla_pkg::*;
(
    input  logic                   sysclk,
    input  logic                   rst,
    qla_reg_bus_if.rd              bus,
    input  logic                   rd_req_valid,   // host holds a credit
    input  logic [`QLA_ADDR_W-1:0] rd_req_addr,
    input  logic [`QLA_DATA_W-1:0] enc_rdata,
    input  logic [`QLA_DATA_W-1:0] mot_rdata,
    output logic                   rd_rsp_valid,
    output logic [`QLA_DATA_W-1:0] rd_rsp_data,
    input  logic                   rd_rsp_ready,
    output logic                   rd_credit       // one credit back per pop
);

    localparam int PTR_W = $clog2(`QLA_RSP_DEPTH);
    localparam int CNT_W = $clog2(`QLA_RSP_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`QLA_RSP_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`QLA_RSP_DEPTH);

    reg_word_u        sel_word;                   // word for the current request
    reg_word_u        rsp_mem [`QLA_RSP_DEPTH];   // response slots
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] rsp_cnt;                    // slots in use
    logic             push;
    logic             pop;

    // -----------------------------------------------------------------------
    // address decode
    // -----------------------------------------------------------------------

    // blocks decode their own word from this, combinationally
    assign bus.raddr = rd_req_addr;

    always_comb begin
        sel_word = '0;   // other spaces read zero
        if (rd_req_addr[15:12] == `QLA_ADDR_MAIN) begin
            if (rd_req_addr[3:0] == `QLA_OFF_ENC_LOAD
                || rd_req_addr[3:0] == `QLA_OFF_ENC_DATA)
                sel_word = enc_rdata;
            else
                sel_word = mot_rdata;   // status, dac, and zero elsewhere
        end
    end

    // -----------------------------------------------------------------------
    // response FIFO
    // -----------------------------------------------------------------------

    // credits keep the host from overfilling, full check is a backstop
    assign push = rd_req_valid && (rsp_cnt != CNT_FULL);
    assign pop  = rd_rsp_valid && rd_rsp_ready;

    // word is captured at the request edge, so a same-cycle write is not seen
    always_ff @(posedge sysclk) begin
        if (push)
            rsp_mem[wr_ptr] <= sel_word;
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            rsp_cnt <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   rsp_cnt <= rsp_cnt + 1'b1;
                2'b01:   rsp_cnt <= rsp_cnt - 1'b1;
                default: rsp_cnt <= rsp_cnt;   // both or neither
            endcase
        end
    end

    // head of queue, valid one cycle after the request at the earliest
    assign rd_rsp_valid = (rsp_cnt != '0);
    assign rd_rsp_data  = rsp_mem[rd_ptr];

    // same cycle as the transfer
    assign rd_credit = pop;

endmodule

// File: src/qla_reg_core.sv
// QLA board register core
`include "qla_consts.svh"

module qla_reg_core (
    input  logic                     sysclk,
    input  logic                     rst,
    input  logic [3:0]               board_id,
    // host write port, accepted every cycle
    input  logic                     wr_valid,
    input  logic [`QLA_ADDR_W-1:0]   wr_addr,
    input  logic [`QLA_DATA_W-1:0]   wr_data,
    // host read port, credit flow control
    input  logic                     rd_req_valid,
    input  logic [`QLA_ADDR_W-1:0]   rd_req_addr,
    output logic                     rd_credit,
    output logic                     rd_rsp_valid,
    output logic [`QLA_DATA_W-1:0]   rd_rsp_data,
    input  logic                     rd_rsp_ready,
    // axis pins
    input  logic [`QLA_NUM_AXES-1:0] enc_a,
    input  logic [`QLA_NUM_AXES-1:0] enc_b,
    input  logic [`QLA_NUM_AXES-1:0] amp_fault_n,
    output logic [`QLA_NUM_AXES-1:0] amp_en
);

    logic [`QLA_DATA_W-1:0] enc_rdata;   // encoder block read word
    logic [`QLA_DATA_W-1:0] mot_rdata;   // motor block read word

    // ---------------------------------------------------------------------------
    // internal bus
    // ---------------------------------------------------------------------------
    qla_reg_bus_if bus0 ();

    assign bus0.wen   = wr_valid;
    assign bus0.waddr = wr_addr;
    assign bus0.wdata = wr_data;   // decoded per block through the union

    qla_enc_ctrl enc0 (
        .sysclk    (sysclk),
        .rst       (rst),
        .bus       (bus0.blk),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .enc_rdata (enc_rdata)
    );

    qla_motor_chan mot0 (
        .sysclk      (sysclk),
        .rst         (rst),
        .bus         (bus0.blk),
        .board_id    (board_id),
        .amp_fault_n (amp_fault_n),
        .amp_en      (amp_en),
        .mot_rdata   (mot_rdata)
    );

    qla_read_path rdp0 (
        .sysclk       (sysclk),
        .rst          (rst),
        .bus          (bus0.rd),      // drives raddr for both blocks
        .rd_req_valid (rd_req_valid),
        .rd_req_addr  (rd_req_addr),
        .enc_rdata    (enc_rdata),
        .mot_rdata    (mot_rdata),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_data  (rd_rsp_data),
        .rd_rsp_ready (rd_rsp_ready),
        .rd_credit    (rd_credit)
    );

endmodule

// File: verif/qla_checker.sv
// QLA register core checker
`include "qla_consts.svh"

module qla_checker (
    input  logic                     sysclk,
    input  logic                     rst,
    input  logic [3:0]               board_id,
    input  logic                     wr_valid,
    input  logic [`QLA_ADDR_W-1:0]   wr_addr,
    input  logic [`QLA_DATA_W-1:0]   wr_data,
    input  logic                     rd_req_valid,
    input  logic [`QLA_ADDR_W-1:0]   rd_req_addr,
    input  logic                     rd_credit,
    input  logic                     rd_rsp_valid,
    input  logic [`QLA_DATA_W-1:0]   rd_rsp_data,
    input  logic                     rd_rsp_ready,
    input  logic [`QLA_NUM_AXES-1:0] enc_a,
    input  logic [`QLA_NUM_AXES-1:0] enc_b,
    input  logic [`QLA_NUM_AXES-1:0] amp_fault_n,
    input  logic [`QLA_NUM_AXES-1:0] amp_en,
    input  int                       test_idx,   // index of the running test
    input  logic                     done,
    output int                       pending,    // responses still expected
    output int                       errors
);

    // ------------------------------------------------------------------------
    // reference model state
    // ------------------------------------------------------------------------
    logic [`QLA_CMD_W-1:0]    m_cmd [`QLA_NUM_AXES];
    logic [`QLA_ENC_W-1:0]    m_pre [`QLA_NUM_AXES];
    logic [`QLA_ENC_W-1:0]    m_cnt [`QLA_NUM_AXES];
    int                       m_low [`QLA_NUM_AXES];   // consecutive low fault samples
    logic [`QLA_NUM_AXES-1:0] m_en, m_safety, m_trip;
    logic [`QLA_NUM_AXES-1:0] m_d1, m_d2;              // fault pin after 1 and 2 flops
    logic [`QLA_NUM_AXES-1:0] m_a, m_b;                // last encoder pins
    logic [`QLA_DATA_W-1:0]   exp_q [$];
    int outstanding, test_errs, tests_run, tests_failed, checks, last_idx;
    bit reported;

    function automatic string test_name(input int idx);
        case (idx)
            1: return "reset";
            2: return "current_cmd";
            3: return "amp_enable";
            4: return "fault_safety";
            5: return "encoder";
            6: return "back_pressure";
            default: return "none";
        endcase
    endfunction

    // expected read word for addr from the model state
    function automatic logic [`QLA_DATA_W-1:0] expected_read(input logic [`QLA_ADDR_W-1:0] addr);
        logic [3:0] chan;
        logic [3:0] off;
        chan = addr[7:4];
        off  = addr[3:0];
        if (addr[15:12] != `QLA_ADDR_MAIN)
            return '0;
        if (chan == 4'd0 && off == `QLA_OFF_STATUS)
            return {4'd0, board_id, 4'd0, m_d2, 8'd0, m_safety, m_en};
        if (chan == 4'd0 || chan > 4'(`QLA_NUM_AXES))
            return '0;
        case (off)
            `QLA_OFF_DAC_CTRL: return {16'd0, m_cmd[chan-1]};
            `QLA_OFF_ENC_LOAD: return {8'd0, m_pre[chan-1]};
            `QLA_OFF_ENC_DATA: return {8'd0, m_cnt[chan-1]};
            default:           return '0;
        endcase
    endfunction

    task automatic error_msg(input string msg);
        $display("Error in %s: %s", test_name(last_idx), msg);
        errors++;
        test_errs++;
    endtask

    // one line per finished test
    task automatic close_test();
        if (last_idx != 0) begin
            tests_run++;
            if (test_errs != 0)
                tests_failed++;
            $display("test %s %s (%0d errors)", test_name(last_idx),
                     (test_errs == 0) ? "ok" : "failed", test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        errors = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        checks = 0;
        last_idx = 0;
        outstanding = 0;
        reported = 0;
        pending = 0;
    end

    // ------------------------------------------------------------------------
    // model update and response compare, on the DUT's sampling edge
    // ------------------------------------------------------------------------
    always @(posedge sysclk) begin
        logic [`QLA_NUM_AXES-1:0] mask;
        logic [3:0]               chan;
        logic                     up;
        logic [`QLA_DATA_W-1:0]   exp;
        if (test_idx != last_idx) begin
            close_test();
            last_idx = test_idx;
        end
        if (rst) begin
            m_en = '0;
            m_safety = '0;
            exp_q.delete();
            outstanding = 0;
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                m_cmd[i] = '0;
                m_pre[i] = '0;
                m_cnt[i] = '0;
                m_low[i] = 0;
            end
        end else begin
            // amp_en as the registers left it before this edge
            if (amp_en !== (m_en & ~m_safety)) begin
                $display("Fail %s: expected amp_en %h, actual %h",
                         test_name(last_idx), m_en & ~m_safety, amp_en);
                errors++;
                test_errs++;
            end
            // response side sees the old state
            if (rd_credit !== (rd_rsp_valid && rd_rsp_ready))
                error_msg("credit pulse does not match a response transfer");
            if (rd_rsp_valid && exp_q.size() == 0) begin
                error_msg("response valid with no request outstanding");
            end else if (rd_rsp_valid && rd_rsp_ready) begin
                exp = exp_q.pop_front();
                checks++;
                if (rd_rsp_data !== exp) begin
                    $display("Fail %s: expected %08h, actual %08h",
                             test_name(last_idx), exp, rd_rsp_data);
                    errors++;
                    test_errs++;
                end
            end
            if (rd_credit)
                outstanding--;
            // request sees state before this edge's write
            if (rd_req_valid) begin
                if (outstanding >= `QLA_RSP_DEPTH)
                    error_msg("read request sent without a credit");
                exp_q.push_back(expected_read(rd_req_addr));
                outstanding++;
            end
            // fault filter on synchronized samples
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (m_en[i] && !m_safety[i] && !m_d2[i])
                    m_low[i]++;
                else
                    m_low[i] = 0;
                m_trip[i] = (m_low[i] >= `QLA_FAULT_FILTER);
            end
            mask = '0;
            chan = wr_addr[7:4];
            if (wr_valid && wr_addr[15:12] == `QLA_ADDR_MAIN) begin
                if (chan == 4'd0 && wr_addr[3:0] == `QLA_OFF_STATUS) begin
                    mask = wr_data[19:16];
                    m_en = (m_en & ~mask) | (wr_data[3:0] & mask);
                end
            end
            m_safety = (m_safety | m_trip) & ~(wr_data[3:0] & mask);   // re-enable clears
            // 4x quadrature from the raw pins
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if ((enc_a[i] ^ m_a[i]) != (enc_b[i] ^ m_b[i])) begin
                    up = (enc_a[i] ^ m_a[i]) ? (enc_a[i] != m_b[i]) : (enc_b[i] == m_a[i]);
                    m_cnt[i] = up ? m_cnt[i] + 1'b1 : m_cnt[i] - 1'b1;
                end
            end
            if (wr_valid && wr_addr[15:12] == `QLA_ADDR_MAIN
                && chan >= 4'd1 && chan <= 4'(`QLA_NUM_AXES)) begin
                if (wr_addr[3:0] == `QLA_OFF_DAC_CTRL)
                    m_cmd[chan-1] = wr_data[15:0];
                if (wr_addr[3:0] == `QLA_OFF_ENC_LOAD) begin
                    m_pre[chan-1] = wr_data[23:0];   // load beats a step
                    m_cnt[chan-1] = wr_data[23:0];
                end
            end
        end
        m_d2 = m_d1;
        m_d1 = amp_fault_n;
        m_a = enc_a;
        m_b = enc_b;
        pending = exp_q.size();
        if (done && !reported) begin
            reported = 1;
            if (exp_q.size() != 0)
                error_msg("responses lost, requests never answered");
            close_test();
            $display("tests %0d, failed %0d, reads checked %0d, errors %0d",
                     tests_run, tests_failed, checks, errors);
        end
    end

endmodule

// File: verif/qla_tb.sv
// QLA register core testbench
`include "qla_consts.svh"

module qla_tb;

    logic                     sysclk;
    logic                     rst;
    logic [3:0]               board_id;
    logic                     wr_valid;
    logic [`QLA_ADDR_W-1:0]   wr_addr;
    logic [`QLA_DATA_W-1:0]   wr_data;
    logic                     rd_req_valid;
    logic [`QLA_ADDR_W-1:0]   rd_req_addr;
    logic                     rd_credit;
    logic                     rd_rsp_valid;
    logic [`QLA_DATA_W-1:0]   rd_rsp_data;
    logic                     rd_rsp_ready;
    logic [`QLA_NUM_AXES-1:0] enc_a, enc_b, amp_fault_n, amp_en;
    int                       test_idx;
    logic                     done;
    int                       pending, errors;
    int                       credits;       // host side credit count
    bit                       rand_ready;    // random back-pressure on
    int                       phase [`QLA_NUM_AXES];
    logic [`QLA_CMD_W-1:0]    cmd;

    qla_reg_core dut0 (.*);

    qla_checker chk0 (.*);

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;
    end

    // one credit spent per request and one back per transfer
    always @(posedge sysclk) begin
        if (rst)
            credits <= `QLA_RSP_DEPTH;
        else
            credits <= credits + (rd_credit ? 1 : 0) - (rd_req_valid ? 1 : 0);
    end

    // response ready, picked at the edge and driven just after it
    initial begin
        logic ready_nxt;
        rd_rsp_ready = 1'b1;
        forever begin
            @(posedge sysclk);
            ready_nxt = rand_ready ? 1'($urandom % 2) : 1'b1;
            #2;
            rd_rsp_ready = ready_nxt;
        end
    end

    function automatic logic [`QLA_ADDR_W-1:0] reg_addr(input int chan, input int off);
        return {`QLA_ADDR_MAIN, 4'h0, 4'(chan), 4'(off)};
    endfunction

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    // tasks start and end 2 units after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #2;
    endtask

    task automatic write_reg(input logic [`QLA_ADDR_W-1:0] addr, input logic [31:0] data);
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        wait_cycles(1);
        wr_valid = 1'b0;
    endtask

    task automatic read_req(input logic [`QLA_ADDR_W-1:0] addr);
        int t;
        t = 0;
        while (credits == 0 && t < 200) begin
            wait_cycles(1);
            t++;
        end
        if (credits == 0) begin
            timeout_fail("no read credit came back");
        end else begin
            rd_req_valid = 1'b1;
            rd_req_addr  = addr;
            wait_cycles(1);
            rd_req_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (pending != 0 && t < 500) begin
            wait_cycles(1);
            t++;
        end
        if (pending != 0)
            timeout_fail("read responses did not drain");
    endtask

    // move one axis n quadrature phases with a leading b going forward
    task automatic step_enc(input int ax, input int n);
        phase[ax] = (phase[ax] + n) & 3;
        enc_a[ax] = (phase[ax] == 1) || (phase[ax] == 2);
        enc_b[ax] = (phase[ax] >= 2);
        wait_cycles(4);
    endtask

    initial begin
        void'($urandom(32'hea35_a77b));
        rst = 1'b1;
        board_id = 4'hA;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_req_valid = 1'b0;
        rd_req_addr = '0;
        rand_ready = 1'b0;
        enc_a = '0;
        enc_b = '0;
        amp_fault_n = '1;
        test_idx = 0;
        done = 1'b0;
        for (int i = 0; i < `QLA_NUM_AXES; i++)
            phase[i] = 0;
        wait_cycles(8);
        rst = 1'b0;
        wait_cycles(2);

        // ---------------------------------------------------------------------
        test_idx = 1;
        read_req(reg_addr(0, `QLA_OFF_STATUS));
        for (int c = 1; c <= 4; c++) begin
            read_req(reg_addr(c, `QLA_OFF_DAC_CTRL));
            read_req(reg_addr(c, `QLA_OFF_ENC_DATA));
        end
        drain();

        test_idx = 2;
        for (int c = 1; c <= 4; c++) begin
            cmd = 16'($urandom);
            write_reg(reg_addr(c, `QLA_OFF_DAC_CTRL), {16'hBEEF, cmd});   // upper bits ignored
            read_req(reg_addr(c, `QLA_OFF_DAC_CTRL));
        end
        for (int c = 5; c <= 15; c++)
            read_req(reg_addr(c, `QLA_OFF_DAC_CTRL));
        for (int s = 1; s <= 15; s++)
            read_req({4'(s), 8'h01, `QLA_OFF_DAC_CTRL});
        drain();

        test_idx = 3;
        write_reg(reg_addr(0, 0), 32'h0003_0001);   // mask 0011
        read_req(reg_addr(0, 0));
        write_reg(reg_addr(0, 0), 32'h0004_000F);   // only axis 2 moves
        read_req(reg_addr(0, 0));
        write_reg(reg_addr(0, 0), 32'h0001_0000);
        wait_cycles(2);
        read_req(reg_addr(0, 0));
        drain();

        test_idx = 4;
        write_reg(reg_addr(0, 0), 32'h000F_000F);
        amp_fault_n[2] = 1'b0;
        wait_cycles(20);
        amp_fault_n[2] = 1'b1;
        wait_cycles(5);
        read_req(reg_addr(0, 0));
        amp_fault_n[0] = 1'b0;   // short glitch
        wait_cycles(3);
        amp_fault_n[0] = 1'b1;
        wait_cycles(5);
        read_req(reg_addr(0, 0));
        write_reg(reg_addr(0, 0), 32'h0004_0004);
        wait_cycles(2);
        read_req(reg_addr(0, 0));
        drain();

        test_idx = 5;
        write_reg(reg_addr(2, `QLA_OFF_ENC_LOAD), 32'h00FF_FFFE);
        write_reg(reg_addr(4, `QLA_OFF_ENC_LOAD), 32'($urandom));
        for (int i = 0; i < 5; i++)
            step_enc(1, 1);
        step_enc(1, 2);          // illegal double step
        for (int i = 0; i < 3; i++) begin
            step_enc(1, 3);
            step_enc(3, 3);
        end
        wait_cycles(4);
        for (int c = 1; c <= 4; c++) begin
            read_req(reg_addr(c, `QLA_OFF_ENC_LOAD));
            read_req(reg_addr(c, `QLA_OFF_ENC_DATA));
        end
        drain();

        test_idx = 6;
        rand_ready = 1'b1;
        for (int i = 0; i < 24; i++)
            read_req(reg_addr($urandom % 5, (i % 2) ? `QLA_OFF_ENC_DATA : 0));
        drain();
        rand_ready = 1'b0;
        wait_cycles(2);

        done = 1'b1;
        wait_cycles(2);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/qla_pkg.sv
src/qla_reg_bus_if.sv
src/qla_enc_ctrl.sv
src/qla_motor_chan.sv
src/qla_read_path.sv
src/qla_reg_core.sv
verif/qla_checker.sv
verif/qla_tb.sv

// File: Makefile
# Verilator build for the QLA register core

VERILATOR ?= verilator
TOP       ?= qla_tb
RTL_TOP   ?= qla_reg_core
FILELIST  ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
